// ==== hw/mul_cfg_pkg.sv ====
package mul_cfg_pkg;

    localparam int unsigned OP_W       = 16;
    localparam int unsigned PROD_W     = 2 * OP_W;
    localparam int unsigned NUM_DIGITS = OP_W / 2;

    // Doubled multiplicand plus the inverted sign bit on top
    localparam int unsigned PP_W = OP_W + 2;

    // Every partial product is stored with its top bit inverted, which adds
    // 2^17 at each digit position. The constant below is
    // -(2^17 * (1 + 4 + ... + 4^7)) mod 2^32 and takes that offset out again.
    // The result is the two's-complement sum of all digit multiples.
    // Bits 17 and up only, so the negate bits at 2i never collide with it
    localparam logic [PROD_W-1:0] SIGN_CORR = 32'h5556_0000;

endpackage

// ==== hw/booth_pkg.sv ====
package booth_pkg;

    typedef enum logic [2:0] {
        ZERO   = 3'd0,
        POS_X  = 3'd1,
        POS_2X = 3'd2,
        NEG_2X = 3'd3,
        NEG_X  = 3'd4
    } booth_op_e;

    // Radix-4 recoding of {b[2i+1], b[2i], b[2i-1]}
    function automatic booth_op_e decode_window(input logic [2:0] window);
        case (window)
            3'b001, 3'b010: return POS_X;
            3'b011:         return POS_2X;
            3'b100:         return NEG_2X;
            3'b101, 3'b110: return NEG_X;
            default:        return ZERO;     // 000 and 111
        endcase
    endfunction

    function automatic logic is_negative(input booth_op_e op);
        return (op == NEG_X) || (op == NEG_2X);
    endfunction

    // Negative digits come back as one's complement, the +1 is added later
    function automatic logic [mul_cfg_pkg::PP_W-1:0] apply_digit(
        input booth_op_e                     op,
        input logic [mul_cfg_pkg::PP_W-1:0] x_ext
    );
        case (op)
            POS_X:   return x_ext;
            POS_2X:  return x_ext << 1;
            NEG_2X:  return ~(x_ext << 1);
            NEG_X:   return ~x_ext;
            default: return '0;
        endcase
    endfunction

endpackage

// ==== hw/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         req_en,
    input  logic                         req_sign,
    input  logic [mul_cfg_pkg::OP_W-1:0] req_op0,
    input  logic [mul_cfg_pkg::OP_W-1:0] req_op1,
    output logic                         stage_valid,
    output logic                         stage_sign,
    output logic [mul_cfg_pkg::OP_W-1:0] stage_op0,
    output logic [mul_cfg_pkg::OP_W-1:0] stage_op1
);

    // One pulse per accepted request
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            stage_valid <= 1'b0;
        end
        else
        begin
            stage_valid <= req_en;
        end
    end

    // Operands only move on a request so the slices stay quiet when idle
    always_ff @(posedge clk)
    begin
        if (req_en)
        begin
            stage_sign <= req_sign;
            stage_op0  <= req_op0;       // Multiplicand
            stage_op1  <= req_op1;       // Multiplier
        end
    end

    a_req_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        req_en |-> !$isunknown({req_sign, req_op0, req_op1})
    );

endmodule

// ==== hw/booth_pp_slice.sv ====
`timescale 1ns/1ps

module booth_pp_slice (
    input  logic [2:0]                   window,
    input  logic [mul_cfg_pkg::OP_W-1:0] multiplicand,
    input  logic                         sign,
    output logic [mul_cfg_pkg::PP_W-1:0] pp,
    output logic                         neg
);

    booth_pkg::booth_op_e                op;
    logic                                ext_sign;
    logic [mul_cfg_pkg::PP_W-1:0]        x_ext;
    logic [mul_cfg_pkg::PP_W-1:0]        mult_sel;

    assign op = booth_pkg::decode_window(window);

    // Unsigned operands extend with zero
    assign ext_sign = sign & multiplicand[mul_cfg_pkg::OP_W-1];

    assign x_ext = {
        {(mul_cfg_pkg::PP_W - mul_cfg_pkg::OP_W){ext_sign}},
        multiplicand
    };

    // 0, +-X or +-2X, one's complement when negative
    assign mult_sel = booth_pkg::apply_digit(op, x_ext);

    // Inverted sign on top instead of a full sign extension
    assign pp = {
        ~mult_sel[mul_cfg_pkg::PP_W-1],
        mult_sel[mul_cfg_pkg::PP_W-2:0]
    };

    assign neg = booth_pkg::is_negative(op);   // +1 at bit 2i downstream

    // Cross check of the recoding against the raw window bits
    always_comb
    begin
        a_neg_digit : assert final (
            $isunknown(window) || (neg == (window[2] && !(&window)))
        );
    end

endmodule

// ==== hw/pp_reduction.sv ====
`timescale 1ns/1ps

module pp_reduction (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           stage_valid,
    input  logic                           sign,
    input  logic [mul_cfg_pkg::OP_W-1:0]   multiplicand,
    input  logic                           op1_msb,
    input  logic [mul_cfg_pkg::NUM_DIGITS-1:0][mul_cfg_pkg::PP_W-1:0] pp_array,
    input  logic [mul_cfg_pkg::NUM_DIGITS-1:0]                        neg_array,
    output logic                           resp_valid,
    output logic [mul_cfg_pkg::PROD_W-1:0] resp_result
);

    logic [mul_cfg_pkg::PROD_W-1:0] rows [mul_cfg_pkg::NUM_DIGITS+2];
    logic [mul_cfg_pkg::PROD_W-1:0] cin_row;
    logic [mul_cfg_pkg::PROD_W-1:0] lvl1 [7];
    logic [mul_cfg_pkg::PROD_W-1:0] lvl2 [5];
    logic [mul_cfg_pkg::PROD_W-1:0] lvl3 [4];
    logic [mul_cfg_pkg::PROD_W-1:0] lvl4 [3];
    logic [mul_cfg_pkg::PROD_W-1:0] lvl5 [2];
    logic [mul_cfg_pkg::PROD_W-1:0] final_sum;

    // Returns {carry, sum}, carry already moved one place left
    function automatic logic [2*mul_cfg_pkg::PROD_W-1:0] csa(
        input logic [mul_cfg_pkg::PROD_W-1:0] a,
        input logic [mul_cfg_pkg::PROD_W-1:0] b,
        input logic [mul_cfg_pkg::PROD_W-1:0] c
    );
        logic [mul_cfg_pkg::PROD_W-1:0] sum;
        logic [mul_cfg_pkg::PROD_W-1:0] carry;
        sum   = a ^ b ^ c;
        carry = (a & b) | (b & c) | (a & c);
        return {carry[mul_cfg_pkg::PROD_W-2:0], 1'b0, sum};
    endfunction

    always_comb
    begin
        cin_row = mul_cfg_pkg::SIGN_CORR;
        for (int i = 0; i < mul_cfg_pkg::NUM_DIGITS; i++)
        begin
            rows[i] = {{(mul_cfg_pkg::PROD_W - mul_cfg_pkg::PP_W){1'b0}}, pp_array[i]}
                      << (2 * i);
            cin_row[2*i] = neg_array[i];  // Completes the one's complement
        end
        rows[mul_cfg_pkg::NUM_DIGITS] = cin_row;

        // Booth reads an unsigned multiplier with its msb set as negative
        if (!sign && op1_msb)
        begin
            rows[mul_cfg_pkg::NUM_DIGITS+1] =
                {multiplicand, {mul_cfg_pkg::OP_W{1'b0}}};
        end
        else
        begin
            rows[mul_cfg_pkg::NUM_DIGITS+1] = '0;
        end
    end

    // 10 -> 7 -> 5 -> 4 -> 3 -> 2 rows
    always_comb
    begin
        {lvl1[1], lvl1[0]} = csa(rows[0], rows[1], rows[2]);
        {lvl1[3], lvl1[2]} = csa(rows[3], rows[4], rows[5]);
        {lvl1[5], lvl1[4]} = csa(rows[6], rows[7], rows[8]);
        lvl1[6]            = rows[9];

        {lvl2[1], lvl2[0]} = csa(lvl1[0], lvl1[1], lvl1[2]);
        {lvl2[3], lvl2[2]} = csa(lvl1[3], lvl1[4], lvl1[5]);
        lvl2[4]            = lvl1[6];

        {lvl3[1], lvl3[0]} = csa(lvl2[0], lvl2[1], lvl2[2]);
        lvl3[2]            = lvl2[3];
        lvl3[3]            = lvl2[4];

        {lvl4[1], lvl4[0]} = csa(lvl3[0], lvl3[1], lvl3[2]);
        lvl4[2]            = lvl3[3];

        {lvl5[1], lvl5[0]} = csa(lvl4[0], lvl4[1], lvl4[2]);
    end

    assign final_sum = lvl5[0] + lvl5[1];   // Carry out beyond bit 31 dropped

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            resp_valid  <= 1'b0;
            resp_result <= '0;
        end
        else
        begin
            resp_valid <= stage_valid;
            if (stage_valid)
            begin
                resp_result <= final_sum;    // Holds over idle cycles
            end
        end
    end

    a_result_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        resp_valid |-> !$isunknown(resp_result)
    );

endmodule

// ==== hw/booth_mult_top.sv ====
`timescale 1ns/1ps

module booth_mult_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           req_en,
    input  logic                           req_sign,
    input  logic [mul_cfg_pkg::OP_W-1:0]   req_op0,
    input  logic [mul_cfg_pkg::OP_W-1:0]   req_op1,
    output logic                           resp_valid,
    output logic [mul_cfg_pkg::PROD_W-1:0] resp_result
);

    logic                                  stage_valid;
    logic                                  stage_sign;
    logic [mul_cfg_pkg::OP_W-1:0]          stage_op0;
    logic [mul_cfg_pkg::OP_W-1:0]          stage_op1;
    logic [mul_cfg_pkg::OP_W:0]            op1_ext;
    logic [mul_cfg_pkg::NUM_DIGITS-1:0][mul_cfg_pkg::PP_W-1:0] pp_array;
    logic [mul_cfg_pkg::NUM_DIGITS-1:0]                        neg_array;

    operand_stage u_operand_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_en      (req_en),
        .req_sign    (req_sign),
        .req_op0     (req_op0),
        .req_op1     (req_op1),
        .stage_valid (stage_valid),
        .stage_sign  (stage_sign),
        .stage_op0   (stage_op0),
        .stage_op1   (stage_op1)
    );

    assign op1_ext = {stage_op1, 1'b0};     // Implicit zero below bit 0

    for (genvar i = 0; i < mul_cfg_pkg::NUM_DIGITS; i++)
    begin : g_digit
        booth_pp_slice u_booth_pp_slice (
            .window       (op1_ext[2*i+2 -: 3]),    // Bits 2i+1 .. 2i-1
            .multiplicand (stage_op0),
            .sign         (stage_sign),
            .pp           (pp_array[i]),
            .neg          (neg_array[i])
        );
    end

    pp_reduction u_pp_reduction (
        .clk          (clk),
        .arst_n       (arst_n),
        .stage_valid  (stage_valid),
        .sign         (stage_sign),
        .multiplicand (stage_op0),
        .op1_msb      (stage_op1[mul_cfg_pkg::OP_W-1]),
        .pp_array     (pp_array),
        .neg_array    (neg_array),
        .resp_valid   (resp_valid),
        .resp_result  (resp_result)
    );

endmodule

// ==== sim/tb_booth_mult.sv ====
`timescale 1ns/1ps

module tb_booth_mult;

    localparam int N_RAND      = 200;
    localparam int N_CORNER    = 14;
    localparam int N_BURST     = 16;
    localparam int N_GAP       = 12;
    localparam int MAX_GAP     = 3;
    localparam int DRAIN       = 5;      // Pipeline drain plus settle per test
    localparam int STIM_CYCLES = 2 + 4 + 2 * (N_RAND + DRAIN) + (N_CORNER + DRAIN)
                                 + (N_BURST + DRAIN) + N_GAP * (MAX_GAP + 1) + DRAIN;
    localparam int CYCLE_LIMIT = STIM_CYCLES + 20;

    logic                           clk;
    logic                           arst_n;
    logic                           req_en;
    logic                           req_sign;
    logic [mul_cfg_pkg::OP_W-1:0]   req_op0;
    logic [mul_cfg_pkg::OP_W-1:0]   req_op1;
    logic                           resp_valid;
    logic [mul_cfg_pkg::PROD_W-1:0] resp_result;

    logic [mul_cfg_pkg::PROD_W-1:0] exp_q [$];
    logic [mul_cfg_pkg::PROD_W-1:0] exp_head;
    logic                           exp_avail;
    logic                           idle_check;
    integer                         seed;
    int                             error_count;
    int                             pass_tests;
    int                             fail_tests;
    int                             cycle_cnt;

    booth_mult_top u_booth_mult_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_en      (req_en),
        .req_sign    (req_sign),
        .req_op0     (req_op0),
        .req_op1     (req_op1),
        .resp_valid  (resp_valid),
        .resp_result (resp_result)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Low 32 bits of the product of sign or zero extended operands
    function automatic logic [31:0] product_of(input logic s, input logic [15:0] a,
                                               input logic [15:0] b);
        logic [31:0] ea;
        logic [31:0] eb;
        ea = s ? {{16{a[15]}}, a} : {16'h0000, a};
        eb = s ? {{16{b[15]}}, b} : {16'h0000, b};
        return ea * eb;
    endfunction

    task automatic send_req(input logic s, input logic [15:0] a, input logic [15:0] b);
        req_en   = 1'b1;
        req_sign = s;
        req_op0  = a;
        req_op1  = b;
        exp_q.push_back(product_of(s, a, b));
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        req_en   = 1'b0;
        req_sign = 1'($random(seed));     // Operand inputs wander while idle
        req_op0  = 16'($random(seed));
        req_op1  = 16'($random(seed));
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic drain_and_report(input int num, input string name, input int errs_before);
        req_en = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (2) @(posedge clk);
        #2;
        if (error_count == errs_before)
        begin
            pass_tests++;
            $display("Test %0d %s: passed", num, name);
        end
        else
        begin
            fail_tests++;
            $display("Test %0d %s: failed with %0d errors", num, name, error_count - errs_before);
        end
    endtask

    // Head of the queue lines up with the pulse seen at the next rising edge
    always @(negedge clk)
    begin
        exp_avail <= (exp_q.size() != 0);
        if (resp_valid && exp_q.size() != 0)
            exp_head <= exp_q.pop_front();
    end

    a_idle_after_reset : assert property (@(posedge clk) disable iff (!arst_n)
        idle_check |-> (!resp_valid && resp_result == '0))
        else begin
            $display("Error at %0t: output active before any request", $time);
            error_count++;
        end

    a_pulse_expected : assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> exp_avail)
        else begin
            $display("A result pulse came out with no request waiting for it");
            error_count++;
        end

    a_product : assert property (@(posedge clk) disable iff (!arst_n)
        (resp_valid && exp_avail) |-> (resp_result == exp_head))
        else begin
            $display("Error at %0t: result %h, expected %h", $time,
                     $sampled(resp_result), $sampled(exp_head));
            error_count++;
        end

    a_latency : assert property (@(posedge clk) disable iff (!arst_n)
        req_en |-> ##2 resp_valid)
        else begin
            $display("A request did not produce a result pulse two edges later");
            error_count++;
        end

    a_no_extra : assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid |-> $past(req_en, 2))
        else begin
            $display("A result pulse came out without a matching request");
            error_count++;
        end

    a_hold : assert property (@(posedge clk) disable iff (!arst_n)
        !resp_valid |-> $stable(resp_result))
        else begin
            $display("Error at %0t: result changed during an idle cycle", $time);
            error_count++;
        end

    initial
    begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Run stopped after %0d cycles, the tests did not finish in time", cycle_cnt);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        int errs;
        int gap;
        req_en      = 1'b0;
        req_sign    = 1'b0;
        req_op0     = '0;
        req_op1     = '0;
        arst_n      = 1'b0;
        idle_check  = 1'b0;
        exp_head    = '0;
        exp_avail   = 1'b0;
        seed        = 25;
        error_count = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        errs       = error_count;
        idle_check = 1'b1;
        idle(4);
        idle_check = 1'b0;
        drain_and_report(1, "idle after reset", errs);

        errs = error_count;
        for (int i = 0; i < N_RAND; i++)
            send_req(1'b1, 16'($random(seed)), 16'($random(seed)));
        drain_and_report(2, "random signed", errs);

        errs = error_count;
        for (int i = 0; i < N_RAND; i++)
            send_req(1'b0, 16'($random(seed)), 16'($random(seed)));
        drain_and_report(3, "random unsigned", errs);

        errs = error_count;
        send_req(1'b1, 16'h0000, 16'h1234);
        send_req(1'b0, 16'hFFFF, 16'h0000);
        send_req(1'b1, 16'h0001, 16'h0001);
        send_req(1'b1, 16'h0001, 16'h8000);
        send_req(1'b0, 16'h0001, 16'hFFFF);
        send_req(1'b1, 16'h7FFF, 16'h7FFF);
        send_req(1'b1, 16'h7FFF, 16'h8000);
        send_req(1'b1, 16'h8000, 16'h8000);
        send_req(1'b0, 16'hFFFF, 16'hFFFF);
        send_req(1'b1, 16'h1357, 16'h8888);    // NEG_2X on every other digit
        send_req(1'b0, 16'hBEEF, 16'h8888);
        send_req(1'b1, 16'hAAAA, 16'hAAAA);
        send_req(1'b0, 16'h5555, 16'hAAAA);
        send_req(1'b1, 16'hFFFF, 16'hCCCC);
        drain_and_report(4, "corner operands", errs);

        errs = error_count;
        for (int i = 0; i < N_BURST; i++)
            send_req(i[0], 16'($random(seed)), 16'($random(seed)));
        drain_and_report(5, "back to back", errs);

        errs = error_count;
        for (int i = 0; i < N_GAP; i++)
        begin
            send_req(i[0], 16'($random(seed)), 16'($random(seed)));
            gap = ($unsigned($random(seed)) % MAX_GAP) + 1;
            idle(gap);
        end
        drain_and_report(6, "idle gaps", errs);

        $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_tests, fail_tests,
                 error_count);
        if (fail_tests == 0 && error_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
hw/mul_cfg_pkg.sv
hw/booth_pkg.sv
hw/operand_stage.sv
hw/booth_pp_slice.sv
hw/pp_reduction.sv
hw/booth_mult_top.sv
sim/tb_booth_mult.sv

// ==== Bender.yml ====
package:
  name: booth_mult

dependencies: {}

sources:
  - hw/mul_cfg_pkg.sv
  - hw/booth_pkg.sv
  - hw/operand_stage.sv
  - hw/booth_pp_slice.sv
  - hw/pp_reduction.sv
  - hw/booth_mult_top.sv
  - target: simulation
    files:
      - sim/tb_booth_mult.sv
